// File: verilog/mic_meter_pkg.sv
// mic meter package with shared sample, level and segment types and I2S framing constants
`default_nettype none

package mic_meter_pkg;

    localparam int sck_half_period = 4;   // system clocks per half bit clock
    localparam int slot_bits       = 32;  // bit clocks per channel slot
    localparam int sample_bits     = 24;  // data bits at the start of each slot

    typedef logic signed [sample_bits - 1:0] sample_t;  // two's complement mic sample

    typedef logic [7:0] level_t;  // peak level, magnitude bits 22..15
    typedef logic [7:0] seg_t;    // a in msb, h (decimal point) in lsb
    typedef logic [3:0] hex_t;

    // what the display shows on its six digits
    typedef struct packed
    {
        level_t  peak;   // two left digits
        sample_t shown;  // upper 16 bits on the four right digits
    } display_t;

endpackage

`default_nettype wire

// File: verilog/inmp441_mic_i2s_receiver.sv
// INMP441 receiver, generates I2S sck and ws and captures left-channel samples with a strobe
`default_nettype none
`timescale 1ns/10ps

module inmp441_mic_i2s_receiver
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sd,
    output logic                   sck,
    output logic                   ws,
    output mic_meter_pkg::sample_t value,
    output logic                   value_strobe
);

    localparam int w_div      = $clog2(mic_meter_pkg::sck_half_period + 1);
    localparam int frame_bits = 2 * mic_meter_pkg::slot_bits;
    localparam int w_bit      = $clog2(frame_bits);
    localparam int n_data     = mic_meter_pkg::sample_bits;

    logic [w_div - 1:0]     div_cnt;
    logic                   half_done;
    logic                   sck_rise;
    logic                   sck_fall;
    logic [w_bit - 1:0]     bit_cnt;       // bit clocks since the left slot began
    logic [w_bit - 1:0]     bit_cnt_next;
    logic                   left_data;
    mic_meter_pkg::sample_t shift;

    assign half_done = div_cnt == w_div'(mic_meter_pkg::sck_half_period - 1);
    assign sck_rise  = half_done & ~sck;
    assign sck_fall  = half_done & sck;

    assign bit_cnt_next = (bit_cnt == w_bit'(frame_bits - 1)) ? '0 : bit_cnt + 1'b1;

    // msb sits one bit clock after the ws edge, so data bits are counts 1..24
    assign left_data = (bit_cnt != '0) && (bit_cnt <= w_bit'(n_data));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (half_done)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            bit_cnt <= '0;
            ws      <= 1'b0;
        end
        else if (sck_fall)
        begin
            bit_cnt <= bit_cnt_next;
            ws      <= bit_cnt_next >= w_bit'(mic_meter_pkg::slot_bits);  // high = right slot
        end
    end

    always_ff @(posedge clk)
        if (sck_rise && left_data)
            shift <= {shift[n_data - 2:0], sd};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            value        <= '0;
            value_strobe <= 1'b0;
        end
        else
        begin
            value_strobe <= 1'b0;
            if (sck_rise && bit_cnt == w_bit'(n_data))  // lsb arrives on this edge
            begin
                value        <= {shift[n_data - 2:0], sd};
                value_strobe <= 1'b1;
            end
        end
    end

    // one sample per frame, never a held strobe
    assert property (@(posedge clk) disable iff (rst) value_strobe |=> !value_strobe);

endmodule

`default_nettype wire

// File: verilog/peak_meter.sv
// peak meter, decaying peak magnitude of the mic samples with a thermometer LED bar
`default_nettype none
`timescale 1ns/10ps

module peak_meter
#(
    parameter int decay_samples = 16,
    parameter int w_led         = 10
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  mic_meter_pkg::sample_t value,
    input  logic                   value_strobe,
    output mic_meter_pkg::level_t  level,
    output logic [w_led - 1:0]     led
);

    localparam int w_decay = $clog2(decay_samples + 1);
    localparam int msb     = $bits(mic_meter_pkg::sample_t) - 1;

    mic_meter_pkg::level_t magnitude;
    logic [w_decay - 1:0]  decay_cnt;  // strobes since the last step down
    logic                  decay_due;

    // bits 22..15, inverted for a negative sample
    assign magnitude = value[msb] ? ~value[msb - 1 -: 8] : value[msb - 1 -: 8];

    assign decay_due = decay_cnt == w_decay'(decay_samples - 1);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            level     <= '0;
            decay_cnt <= '0;
        end
        else if (value_strobe)
        begin
            if (magnitude > level)
            begin
                level     <= magnitude;
                decay_cnt <= '0;  // a fresh peak holds for a full decay period
            end
            else if (decay_due)
            begin
                decay_cnt <= '0;
                if (level != '0)
                    level <= level - 1'b1;
            end
            else
                decay_cnt <= decay_cnt + 1'b1;
        end
    end

    // bar segment k lights at level (k+1)*256/(w_led+1)
    always_comb
    begin
        for (int k = 0; k < w_led; k++)
            led[k] = int'(level) >= ((k + 1) * 256) / (w_led + 1);
    end

    assert property (@(posedge clk) disable iff (rst) ((led + 1'b1) & led) == '0);

endmodule

`default_nettype wire

// File: verilog/sample_hold.sv
// sample hold, debounced key toggles a freeze of the displayed mic sample
`default_nettype none
`timescale 1ns/10ps

module sample_hold
#(
    parameter int debounce_cycles = 1000
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   key,
    input  mic_meter_pkg::sample_t value,
    input  logic                   value_strobe,
    output mic_meter_pkg::sample_t held
);

    localparam int w_cnt = $clog2(debounce_cycles + 1);

    logic [1:0]         key_sync;    // key comes straight from a pin
    logic               key_stable;
    logic [w_cnt - 1:0] stable_cnt;
    logic               accept;
    logic               freeze;

    assign accept = (key_sync[1] != key_stable) && (stable_cnt == w_cnt'(debounce_cycles - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            key_sync   <= '0;
            key_stable <= 1'b0;
            stable_cnt <= '0;
            freeze     <= 1'b0;
        end
        else
        begin
            key_sync <= {key_sync[0], key};

            if (key_sync[1] == key_stable || accept)
                stable_cnt <= '0;  // any bounce restarts the count
            else
                stable_cnt <= stable_cnt + 1'b1;

            if (accept)
                key_stable <= key_sync[1];

            if (accept && key_sync[1])  // press edge only
                freeze <= ~freeze;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            held <= '0;
        else if (value_strobe && !freeze)
            held <= value;
    end

endmodule

`default_nettype wire

// File: verilog/seven_seg_display.sv
// seven segment display, scans six digits showing peak level and sample in hex
`default_nettype none
`timescale 1ns/10ps

module seven_seg_display
#(
    parameter int refresh_cycles = 5000,
    parameter int w_digit        = 6
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  mic_meter_pkg::display_t shown,
    output mic_meter_pkg::seg_t     abcdefgh,
    output logic [w_digit - 1:0]    digit
);

    localparam int w_cnt     = $clog2(refresh_cycles + 1);
    localparam int n_nibbles = ($bits(mic_meter_pkg::level_t) + 16) / 4;
    localparam int n_shown   = (w_digit < n_nibbles) ? w_digit : n_nibbles;
    localparam int s_msb     = $bits(mic_meter_pkg::sample_t) - 1;

    logic [w_cnt - 1:0]         refresh_cnt;
    logic                       tick;
    logic [w_digit - 1:0]       digit_next;
    logic [n_nibbles * 4 - 1:0] nibbles;     // digit 0 in the low nibble
    mic_meter_pkg::hex_t        nibble;

    function automatic mic_meter_pkg::seg_t hex_to_seg(input mic_meter_pkg::hex_t hex);
        case (hex)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;  // f
        endcase
    endfunction

    assign tick       = refresh_cnt == w_cnt'(refresh_cycles - 1);
    assign digit_next = tick ? {digit[w_digit - 2:0], digit[w_digit - 1]} : digit;
    assign nibbles    = {shown.peak, shown.shown[s_msb -: 16]};

    // segments follow the digit that is lit on the next clock
    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < n_shown; i++)
            if (digit_next[i])
                nibble = nibbles[i * 4 +: 4];
    end

    always_ff @(posedge clk)
    begin
        if (rst || tick)
            refresh_cnt <= '0;
        else
            refresh_cnt <= refresh_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            digit    <= w_digit'(1);
            abcdefgh <= hex_to_seg('0);
        end
        else
        begin
            digit    <= digit_next;
            abcdefgh <= hex_to_seg(nibble);
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot(digit));

endmodule

`default_nettype wire

// File: verilog/top.sv
// design top, peak meter and sample hold feeding the multiplexed hex display
`default_nettype none
`timescale 1ns/10ps

module top
#(
    parameter int clk_mhz = 50,
    parameter int w_key   = 2,
    parameter int w_sw    = 9,
    parameter int w_led   = 10,
    parameter int w_digit = 6
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [w_key - 1:0]     key,
    input  mic_meter_pkg::sample_t mic,
    input  logic                   mic_strobe,
    output logic [w_led - 1:0]     led,
    output mic_meter_pkg::seg_t    abcdefgh,
    output logic [w_digit - 1:0]   digit
);

    localparam int refresh_cycles  = clk_mhz * 100;   // 100 us per digit
    localparam int debounce_cycles = clk_mhz * 1000;  // 1 ms
    localparam int decay_samples   = 16;

    mic_meter_pkg::level_t   level;
    mic_meter_pkg::sample_t  held;
    mic_meter_pkg::display_t shown;

    assign shown = '{peak: level, shown: held};

    peak_meter
    #(
        .decay_samples ( decay_samples ),
        .w_led         ( w_led         )
    )
    i_peak_meter
    (
        .clk          ( clk        ),
        .rst          ( rst        ),
        .value        ( mic        ),
        .value_strobe ( mic_strobe ),
        .level        ( level      ),
        .led          ( led        )
    );

    sample_hold
    #(
        .debounce_cycles ( debounce_cycles )
    )
    i_sample_hold
    (
        .clk          ( clk        ),
        .rst          ( rst        ),
        .key          ( key [0]    ),
        .value        ( mic        ),
        .value_strobe ( mic_strobe ),
        .held         ( held       )
    );

    seven_seg_display
    #(
        .refresh_cycles ( refresh_cycles ),
        .w_digit        ( w_digit        )
    )
    i_display
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .shown    ( shown    ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

`default_nettype wire

// File: verilog/board_specific_top.sv
// MAX10 board wrapper for the mic meter, maps pins, HEX polarity and INMP441 wiring
`default_nettype none
`timescale 1ns/10ps

module board_specific_top
#(
    parameter int clk_mhz = 50,
    parameter int w_key   = 2,
    parameter int w_sw    = 9,   // plus one more switch for reset
    parameter int w_led   = 10,
    parameter int w_digit = 6,
    parameter int w_gpio  = 36
)
(
    input  logic                 MAX10_CLK1_50,
    input  logic [w_key - 1:0]   KEY,
    input  logic [w_sw:0]        SW,
    output logic [w_led - 1:0]   LEDR,
    output logic [7:0]           HEX0,
    output logic [7:0]           HEX1,
    output logic [7:0]           HEX2,
    output logic [7:0]           HEX3,
    output logic [7:0]           HEX4,
    output logic [7:0]           HEX5,
    output logic                 VGA_HS,
    output logic                 VGA_VS,
    output logic [3:0]           VGA_R,
    output logic [3:0]           VGA_G,
    output logic [3:0]           VGA_B,
    inout  wire  [w_gpio - 1:0]  GPIO
);

    mic_meter_pkg::seg_t    abcdefgh;
    mic_meter_pkg::seg_t    hex_code;    // hgfedcba, active low
    logic [w_digit - 1:0]   digit;
    mic_meter_pkg::sample_t mic;
    logic                   mic_strobe;

    top
    #(
        .clk_mhz ( clk_mhz ),
        .w_key   ( w_key   ),
        .w_sw    ( w_sw    ),
        .w_led   ( w_led   ),
        .w_digit ( w_digit )
    )
    i_top
    (
        .clk        ( MAX10_CLK1_50 ),
        .rst        ( SW [w_sw]     ),
        .key        ( ~KEY          ),  // keys are active low on the board
        .mic        ( mic           ),
        .mic_strobe ( mic_strobe    ),
        .led        ( LEDR          ),
        .abcdefgh   ( abcdefgh      ),
        .digit      ( digit         )
    );

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk          ( MAX10_CLK1_50 ),
        .rst          ( SW [w_sw]     ),
        .sd           ( GPIO [0]      ),
        .sck          ( GPIO [1]      ),
        .ws           ( GPIO [3]      ),
        .value        ( mic           ),
        .value_strobe ( mic_strobe    )
    );

    // HEX pins take segment a on bit 0
    always_comb
    begin
        for (int i = 0; i < $bits(abcdefgh); i++)
            hex_code[i] = ~abcdefgh[$bits(abcdefgh) - 1 - i];
    end

    assign HEX0 = digit[0] ? hex_code : '1;
    assign HEX1 = digit[1] ? hex_code : '1;
    assign HEX2 = digit[2] ? hex_code : '1;
    assign HEX3 = digit[3] ? hex_code : '1;
    assign HEX4 = digit[4] ? hex_code : '1;
    assign HEX5 = digit[5] ? hex_code : '1;

    assign VGA_HS = 1'b0;
    assign VGA_VS = 1'b0;
    assign VGA_R  = '0;
    assign VGA_G  = '0;
    assign VGA_B  = '0;

    assign GPIO[5] = 1'b0;  // L/R select low puts the mic in the left slot
    assign GPIO[4] = 1'b0;  // mic ground
    assign GPIO[2] = 1'b1;  // mic supply

endmodule

`default_nettype wire

// File: bench/i2s_mic_model.sv
// INMP441 behavioral model, shifts a programmed left sample out on sd for an I2S master
`default_nettype none
`timescale 1ns/10ps

module i2s_mic_model
(
    input  logic                   sck,
    input  logic                   ws,
    input  mic_meter_pkg::sample_t sample,
    output logic                   sd
);

    localparam int frame_bits = 2 * mic_meter_pkg::slot_bits;
    localparam int n_data     = mic_meter_pkg::sample_bits;

    logic                   ws_prev;
    int                     slot_pos;   // rising sck edges since the left slot began
    mic_meter_pkg::sample_t word;       // sample being shifted out in this frame

    initial
    begin
        ws_prev  = 1'b1;  // first rising edge after reset opens a left slot
        slot_pos = frame_bits;
        word     = '0;
        sd       = 1'b0;
    end

    // ws is stable on rising sck, it moved on the previous falling edge
    always @(posedge sck)
    begin
        if (!ws && ws_prev)
        begin
            slot_pos <= 0;
            word     <= sample;  // a new sample only takes effect at a frame start
        end
        else if (slot_pos < frame_bits)
            slot_pos <= slot_pos + 1;
        ws_prev <= ws;
    end

    // msb goes out one bit clock after the ws edge, then 23 more bits, then zeros
    always @(negedge sck)
        sd <= (slot_pos < n_data) ? word[n_data - 1 - slot_pos] : 1'b0;

endmodule

`default_nettype wire

// File: bench/tb_board.sv
// board level testbench for the mic meter, drives I2S samples and the key, reads LEDs and HEX
`default_nettype none
`timescale 1ns/10ps

module tb_board;

    localparam int clk_mhz       = 1;
    localparam int w_led         = 10;
    localparam int refresh_clks  = clk_mhz * 100;
    localparam int scan_clks     = 6 * refresh_clks;
    localparam int debounce_clks = clk_mhz * 1000;
    localparam int frame_clks    = 4 * mic_meter_pkg::slot_bits * mic_meter_pkg::sck_half_period;
    localparam int decay_clks    = 16 * frame_clks;                // one level step
    localparam int update_clks   = 2 * frame_clks + 2 * scan_clks;  // sample in, seen on pins

    logic                   clk;
    logic [1:0]             key;
    logic [9:0]             sw;
    logic [w_led - 1:0]     ledr;
    logic [7:0]             hex0;
    logic [7:0]             hex1;
    logic [7:0]             hex2;
    logic [7:0]             hex3;
    logic [7:0]             hex4;
    logic [7:0]             hex5;
    logic                   vga_hs;
    logic                   vga_vs;
    logic [3:0]             vga_r;
    logic [3:0]             vga_g;
    logic [3:0]             vga_b;
    wire  [35:0]            gpio;
    mic_meter_pkg::sample_t mic_sample;
    int                     cycle;
    int                     seed;

    board_specific_top #(.clk_mhz (clk_mhz)) board_specific_top_i
    (
        .MAX10_CLK1_50 ( clk    ),
        .KEY           ( key    ),
        .SW            ( sw     ),
        .LEDR          ( ledr   ),
        .HEX0          ( hex0   ),
        .HEX1          ( hex1   ),
        .HEX2          ( hex2   ),
        .HEX3          ( hex3   ),
        .HEX4          ( hex4   ),
        .HEX5          ( hex5   ),
        .VGA_HS        ( vga_hs ),
        .VGA_VS        ( vga_vs ),
        .VGA_R         ( vga_r  ),
        .VGA_G         ( vga_g  ),
        .VGA_B         ( vga_b  ),
        .GPIO          ( gpio   )
    );

    i2s_mic_model mic_i
    (
        .sck    ( gpio [1]   ),
        .ws     ( gpio [3]   ),
        .sample ( mic_sample ),
        .sd     ( gpio [0]   )
    );

    always #10 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
            stop_with_error($sformatf("Fail %s expected %0h actual %0h", name, expected, actual));
    endtask

    function automatic logic [7:0] hex_pins(input int n);
        case (n)
            0:       return hex0;
            1:       return hex1;
            2:       return hex2;
            3:       return hex3;
            4:       return hex4;
            default: return hex5;
        endcase
    endfunction

    // pins are active low with segment a on bit 0 and the point on bit 7
    function automatic int segments_to_hex(input logic [7:0] pins);
        case (~pins)
            8'h3f:   return 0;
            8'h06:   return 1;
            8'h5b:   return 2;
            8'h4f:   return 3;
            8'h66:   return 4;
            8'h6d:   return 5;
            8'h7d:   return 6;
            8'h07:   return 7;
            8'h7f:   return 8;
            8'h6f:   return 9;
            8'h77:   return 10;
            8'h7c:   return 11;
            8'h39:   return 12;
            8'h5e:   return 13;
            8'h79:   return 14;
            8'h71:   return 15;
            default: return -1;  // not a hex glyph, or the point is lit
        endcase
    endfunction

    function automatic logic [7:0] magnitude(input mic_meter_pkg::sample_t s);
        if (s[23])
            return ~s[22:15];
        return s[22:15];
    endfunction

    function automatic logic [w_led - 1:0] thermometer(input logic [7:0] level);
        logic [w_led - 1:0] bar;
        for (int k = 0; k < w_led; k++)
            bar[k] = int'(level) >= ((k + 1) * 256) / (w_led + 1);
        return bar;
    endfunction

    // bits 23..21 are forced so each test knows the magnitude range
    function automatic mic_meter_pkg::sample_t random_sample(input logic [2:0] top_bits);
        logic [31:0] word;
        word         = $random(seed);
        word[23:21]  = top_bits;
        return word[23:0];
    endfunction

    // one pass over the scan with digit n in nibble n
    task automatic read_display(output logic [23:0] digits);
        logic [5:0] seen;
        logic [7:0] pins;
        int         hex;
        int         waited;
        seen   = '0;
        digits = '0;
        waited = 0;
        while (seen != 6'h3f)
        begin
            @(negedge clk);
            for (int n = 0; n < 6; n++)
            begin
                pins = hex_pins(n);
                if (pins != 8'hff)
                begin
                    hex = segments_to_hex(pins);
                    if (hex < 0)
                        stop_with_error($sformatf("HEX%0d shows an unknown code %h", n, pins));
                    digits[n * 4 +: 4] = hex[3:0];
                    seen[n] = 1'b1;
                end
            end
            waited++;
            if (waited > 2 * scan_clks)
                stop_with_error($sformatf("some HEX digits never lit, seen mask %b", seen));
        end
    endtask

    // two equal scans in a row, so no reading mixes old and new digits
    task automatic read_stable_display(output logic [23:0] digits);
        logic [23:0] previous;
        int          tries;
        tries = 0;
        read_display(previous);
        read_display(digits);
        while (digits != previous)
        begin
            tries++;
            if (tries > 8)
                stop_with_error("HEX digits kept changing from one scan to the next");
            previous = digits;
            read_display(digits);
        end
    endtask

    task automatic set_sample(input mic_meter_pkg::sample_t s);
        @(posedge clk);
        mic_sample <= s;
    endtask

    task automatic press_key();
        @(posedge clk);
        key[0] <= 1'b0;
        repeat (debounce_clks + debounce_clks / 4) @(posedge clk);
        key[0] <= 1'b1;
        repeat (debounce_clks + debounce_clks / 4) @(posedge clk);
    endtask

    task automatic wait_for_shown(input string name, input logic [15:0] expected);
        logic [23:0] digits;
        int          deadline;
        deadline = cycle + update_clks;
        do
        begin
            read_stable_display(digits);
        end
        while (digits[15:0] != expected && cycle < deadline);
        check_equal(name, expected, digits[15:0]);
    endtask

    // level and bar can dip by one for a frame while a steady sample repeats
    task automatic wait_for_peak(input string name, input logic [7:0] expected);
        logic [23:0]        digits;
        logic [w_led - 1:0] bar;
        int                 deadline;
        deadline = cycle + update_clks;
        do
        begin
            read_stable_display(digits);
            bar = ledr;
        end
        while ((digits[23:16] != expected || bar != thermometer(expected)) && cycle < deadline);
        check_equal({name, " digits"}, expected, digits[23:16]);
        check_equal({name, " bar"}, thermometer(expected), bar);
    endtask

    task automatic test_reset();
        logic [23:0] digits;
        @(negedge clk);
        check_equal("reset bar", 0, ledr);
        check_equal("vga pins", 0, {vga_hs, vga_vs, vga_r, vga_g, vga_b});
        check_equal("mic pin ties", 3'b001, {gpio[5], gpio[4], gpio[2]});  // select, ground, supply
        read_stable_display(digits);
        check_equal("reset digits", 0, digits);
    endtask

    task automatic test_freeze(input mic_meter_pkg::sample_t old_sample);
        mic_meter_pkg::sample_t new_sample;
        logic [23:0]            digits;
        new_sample = random_sample(3'b000);
        while (new_sample[23:8] == old_sample[23:8])
            new_sample = random_sample(3'b000);
        press_key();  // freeze on
        set_sample(new_sample);
        repeat (update_clks) @(posedge clk);
        read_stable_display(digits);
        check_equal("freeze holds", old_sample[23:8], digits[15:0]);
        press_key();  // freeze off
        wait_for_shown("freeze released", new_sample[23:8]);
    endtask

    task automatic test_peak();
        mic_meter_pkg::sample_t pos_sample;
        mic_meter_pkg::sample_t neg_sample;
        logic [7:0]             larger;
        pos_sample = random_sample(3'b010);  // magnitude 128..191
        neg_sample = random_sample(3'b100);  // magnitude 192..255
        set_sample(pos_sample);
        wait_for_peak("positive peak", magnitude(pos_sample));
        set_sample(neg_sample);
        larger = (magnitude(pos_sample) > magnitude(neg_sample)) ? magnitude(pos_sample)
                                                                 : magnitude(neg_sample);
        wait_for_peak("larger peak", larger);
    endtask

    task automatic test_decay();
        logic [23:0] digits;
        logic [7:0]  prev;
        logic [7:0]  now;
        int          deadline;
        int          last_drop;
        int          drops;
        int          interval;
        set_sample('0);
        repeat (2 * frame_clks) @(posedge clk);  // let the frame in flight finish
        read_stable_display(digits);
        prev      = digits[23:16];
        deadline  = cycle + (int'(prev) + 2) * decay_clks + 4 * scan_clks;
        last_drop = cycle;
        drops     = 0;
        while (prev != 8'h00)
        begin
            if (cycle > deadline)
                stop_with_error("peak level did not decay to zero in time");
            read_stable_display(digits);
            now = digits[23:16];
            if (now != prev)
            begin
                check_equal("decay step", prev - 8'd1, now);
                interval = cycle - last_drop;
                // the first drop comes at an arbitrary point of the decay count
                if (drops > 0 && (interval < decay_clks - 3 * scan_clks ||
                                  interval > decay_clks + 3 * scan_clks))
                    check_equal("decay interval", decay_clks, interval);
                last_drop = cycle;
                drops++;
            end
            prev = now;
        end
        check_equal("bar after decay", 0, ledr);
    endtask

    initial
    begin
        mic_meter_pkg::sample_t live;
        clk        = 1'b0;
        cycle      = 0;
        seed       = 33066;
        sw         = 10'h200;  // reset switch on
        key        = 2'b11;    // keys released
        mic_sample = '0;
        repeat (4) @(posedge clk);
        sw <= '0;

        test_reset();

        live = random_sample(3'b000);
        if (live[0])
            live[23:21] = 3'b111;  // small negative, keeps the peak low
        set_sample(live);
        wait_for_shown("live sample", live[23:8]);

        test_freeze(live);
        test_peak();
        test_decay();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: board_specific_top.f
verilog/mic_meter_pkg.sv
verilog/inmp441_mic_i2s_receiver.sv
verilog/peak_meter.sv
verilog/sample_hold.sv
verilog/seven_seg_display.sv
verilog/top.sv
verilog/board_specific_top.sv
bench/i2s_mic_model.sv
bench/tb_board.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_board -f board_specific_top.f \
    -o sim_board > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_board > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
